// ==== caster.f ====
+incdir+verif
logic/caster_pkg.sv
logic/scan_timing.sv
logic/op_sequencer.sv
logic/pixel_waveform.sv
logic/epd_signal_gen.sv
logic/caster.sv
verif/caster_tb.sv

// ==== logic/caster.sv ====
`timescale 1ns/100ps

module caster import caster_pkg::*; #(
    parameter int H_FP              = 10,
    parameter int H_SYNC            = 10,
    parameter int H_BP              = 120,
    parameter int H_ACT             = 400,
    parameter int V_FP              = 45,
    parameter int V_SYNC            = 1,
    parameter int V_BP              = 2,
    parameter int V_ACT             = 1200,
    parameter int INIT_PHASES       = 8,
    parameter int INIT_PHASE_FRAMES = 42
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        sys_ready,
    // Luminance input, four Y4 pixels per clock
    input  logic        vin_vsync,
    input  logic [15:0] vin_pixel,
    input  logic        vin_valid,
    output logic        vin_ready,
    // Framebuffer state read
    output logic        b_trigger,
    input  logic [63:0] bi_pixel,
    input  logic        bi_valid,
    output logic        bi_ready,
    // Framebuffer state write-back
    output logic [63:0] bo_pixel,
    output logic        bo_valid,
    // Panel lines
    output logic        epd_gdoe,
    output logic        epd_gdclk,
    output logic        epd_gdsp,
    output logic        epd_sdclk,
    output logic        epd_sdle,
    output logic        epd_sdoe,
    output logic [7:0]  epd_sd,
    output logic        epd_sdce0
);

    scan_region_t region;
    op_mode_t     op;
    logic         frame_end;

    // Both sources are fetched in the same window
    assign vin_ready = region.proc_act;
    assign bi_ready  = region.proc_act;

    scan_timing #(
        .H_FP   (H_FP),
        .H_SYNC (H_SYNC),
        .H_BP   (H_BP),
        .H_ACT  (H_ACT),
        .V_FP   (V_FP),
        .V_SYNC (V_SYNC),
        .V_BP   (V_BP),
        .V_ACT  (V_ACT)
    ) i_scan (
        .clk       (clk),
        .rst       (rst),
        .sys_ready (sys_ready),
        .vin_vsync (vin_vsync),
        .region    (region),
        .frame_end (frame_end)
    );

    op_sequencer #(
        .INIT_PHASES       (INIT_PHASES),
        .INIT_PHASE_FRAMES (INIT_PHASE_FRAMES)
    ) i_op (
        .clk       (clk),
        .rst       (rst),
        .frame_end (frame_end),
        .op        (op)
    );

    pixel_waveform i_pix (
        .clk       (clk),
        .rst       (rst),
        .region    (region),
        .op        (op),
        .vin_pixel (vin_pixel),
        .vin_valid (vin_valid),
        .bi_pixel  (bi_pixel),
        .bi_valid  (bi_valid),
        .bo_pixel  (bo_pixel),
        .sd        (epd_sd)
    );

    epd_signal_gen i_sig (
        .clk      (clk),
        .rst      (rst),
        .region   (region),
        .gdoe     (epd_gdoe),
        .gdclk    (epd_gdclk),
        .gdsp     (epd_gdsp),
        .sdclk    (epd_sdclk),
        .sdle     (epd_sdle),
        .sdoe     (epd_sdoe),
        .sdce0    (epd_sdce0),
        .trigger  (b_trigger),
        .bo_valid (bo_valid)
    );

endmodule

// ==== logic/caster_pkg.sv ====
package caster_pkg;

    ////////////////////////////////////////
    // Drive codes and pixel state
    ////////////////////////////////////////

    // Per-pixel source driver code
    typedef enum logic [1:0] {
        DRIVE_NONE  = 2'b00,
        DRIVE_BLACK = 2'b01,
        DRIVE_WHITE = 2'b10
    } drive_t;

    // Mode field of the framebuffer state word
    typedef enum logic [1:0] {
        MODE_NORMAL_LUT = 2'b00,
        MODE_FAST_MONO  = 2'b01,
        MODE_FAST_GREY  = 2'b10,
        MODE_RESERVED   = 2'b11
    } pixel_mode_t;

    // 16-bit state word, prev[0] is the shown colour (1 white)
    typedef struct packed {
        pixel_mode_t mode;
        logic [3:0]  reserved;
        logic [5:0]  frame_cnt;
        logic [3:0]  prev;
    } pixel_state_t;

    // Fast mono transition lengths
    parameter logic [5:0] FASTM_B2W_FRAMES    = 6'd10;
    parameter logic [5:0] FASTM_W2B_FRAMES    = 6'd10;
    parameter logic [5:0] FASTM_REVERSE_BONUS = 6'd2;

    ////////////////////////////////////////
    // Scan and pipeline
    ////////////////////////////////////////

    parameter int VS_DELAY       = 8;
    parameter int PIPELINE_DELAY = 2;
    parameter int PIXELS_PER_CLK = 4;

    // Region flags from the scan counters
    typedef struct packed {
        logic vfp;
        logic vsync;
        logic vbp;
        logic vact;
        logic hfp;
        logic hsync;
        logic hbp;
        logic hact;
        logic act;
        logic proc_act;
        logic waiting;
    } scan_region_t;

    // Operation state seen by the pixel path
    typedef struct packed {
        logic   init;
        drive_t init_drive;
    } op_mode_t;

endpackage

// ==== logic/epd_signal_gen.sv ====
`timescale 1ns/100ps

module epd_signal_gen import caster_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  scan_region_t region,
    output logic         gdoe,
    output logic         gdclk,
    output logic         gdsp,
    output logic         sdclk,
    output logic         sdle,
    output logic         sdoe,
    output logic         sdce0,
    output logic         trigger,
    output logic         bo_valid
);

    logic v_out_en;
    logic gdclk_pre;
    logic sdclk_en;

    ////////////////////////////////////////
    // Gate driver
    ////////////////////////////////////////

    // Output enables held off through the front porch
    assign v_out_en = region.vsync || region.vbp || region.vact;
    assign gdoe     = v_out_en;

    // Start pulse, active low
    assign gdsp = !region.vsync;

    // Gate clock trails the line decode by one cycle
    assign gdclk_pre = region.hsync || region.hbp || region.hact;

    always_ff @(posedge clk) begin
        if (rst) begin
            gdclk <= 1'b0;
        end else begin
            gdclk <= gdclk_pre;
        end
    end

    ////////////////////////////////////////
    // Source driver
    ////////////////////////////////////////

    assign sdoe = v_out_en;

    // Latch enable in horizontal sync
    assign sdle = region.hsync;

    // Chip enable, active low, over the data columns
    assign sdce0 = !region.act;

    // Shift clock off in the back porch
    assign sdclk_en = region.hfp || region.hsync || region.hact;
    assign sdclk    = sdclk_en ? ~clk : 1'b0;

    ////////////////////////////////////////
    // Framebuffer side
    ////////////////////////////////////////

    assign trigger  = region.waiting;
    assign bo_valid = region.act;

endmodule

// ==== logic/op_sequencer.sv ====
`timescale 1ns/100ps

module op_sequencer import caster_pkg::*; #(
    parameter int INIT_PHASES       = 8,
    parameter int INIT_PHASE_FRAMES = 42
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     frame_end,
    output op_mode_t op
);

    localparam int PW = $clog2(INIT_PHASES + 1);
    localparam int FW = $clog2(INIT_PHASE_FRAMES + 1);
    localparam logic [PW-1:0] LAST_PHASE = PW'(INIT_PHASES - 1);
    localparam logic [FW-1:0] LAST_FRAME = FW'(INIT_PHASE_FRAMES - 1);

    logic          init;
    logic [PW-1:0] phase_cnt;
    logic [FW-1:0] frame_cnt;

    ////////////////////////////////////////
    // Init frame counting
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            init      <= 1'b1;
            phase_cnt <= '0;
            frame_cnt <= '0;
        end else if (init && frame_end) begin
            if (frame_cnt == LAST_FRAME) begin
                frame_cnt <= '0;
                if (phase_cnt == LAST_PHASE) begin
                    // Last init frame done, normal from here on
                    init      <= 1'b0;
                    phase_cnt <= '0;
                end else begin
                    phase_cnt <= phase_cnt + PW'(1);
                end
            end else begin
                frame_cnt <= frame_cnt + FW'(1);
            end
        end
    end

    // Even phases black, odd phases white, rest frame at the end
    always_comb begin
        op.init = init;
        if (frame_cnt == LAST_FRAME) begin
            op.init_drive = DRIVE_NONE;
        end else if (phase_cnt[0]) begin
            op.init_drive = DRIVE_WHITE;
        end else begin
            op.init_drive = DRIVE_BLACK;
        end
    end

endmodule

// ==== logic/pixel_waveform.sv ====
`timescale 1ns/100ps

module pixel_waveform import caster_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  scan_region_t                  region,
    input  op_mode_t                      op,
    input  logic [4*PIXELS_PER_CLK-1:0]   vin_pixel,
    input  logic                          vin_valid,
    input  logic [16*PIXELS_PER_CLK-1:0]  bi_pixel,
    input  logic                          bi_valid,
    output logic [16*PIXELS_PER_CLK-1:0]  bo_pixel,
    output logic [2*PIXELS_PER_CLK-1:0]   sd
);

    logic                         accept;
    logic [2*PIXELS_PER_CLK-1:0]  sd_comb;
    logic [16*PIXELS_PER_CLK-1:0] bo_comb;

    assign accept = region.proc_act && vin_valid && bi_valid;

    ////////////////////////////////////////
    // Per-lane fast mono decision
    ////////////////////////////////////////

    for (genvar i = 0; i < PIXELS_PER_CLK; i++) begin : g_lane
        pixel_state_t st_in;
        pixel_state_t st_out;
        drive_t       drv;
        drive_t       tgt_drive;
        logic         tgt;
        logic         same;
        logic [5:0]   full;

        assign st_in     = pixel_state_t'(bi_pixel[16*i +: 16]);
        // Only the top bit of the nibble matters in mono
        assign tgt       = vin_pixel[4*i+3];
        assign same      = (tgt == st_in.prev[0]);
        assign tgt_drive = tgt ? DRIVE_WHITE : DRIVE_BLACK;
        assign full      = tgt ? FASTM_B2W_FRAMES : FASTM_W2B_FRAMES;

        always_comb begin
            st_out = st_in;
            drv    = DRIVE_NONE;
            if (op.init) begin
                drv          = op.init_drive;
                st_out       = '0;
                st_out.mode  = MODE_FAST_MONO;
                st_out.prev  = 4'd1;
            end else if (st_in.mode == MODE_FAST_MONO) begin
                if (st_in.frame_cnt == 6'd0) begin
                    // Settled pixel, start a transition on change
                    if (!same) begin
                        drv              = tgt_drive;
                        st_out.frame_cnt = full;
                        st_out.prev      = {3'b000, tgt};
                    end
                end else begin
                    drv = tgt_drive;
                    if (same) begin
                        st_out.frame_cnt = st_in.frame_cnt - 6'd1;
                    end else begin
                        // Reversal mid-way, undo what was driven
                        st_out.frame_cnt = full - st_in.frame_cnt + FASTM_REVERSE_BONUS;
                        st_out.prev      = {3'b000, tgt};
                    end
                end
            end else begin
                // LUT, grey and reserved modes are not handled
                st_out = '0;
            end
        end

        assign sd_comb[2*i +: 2]  = drv;
        assign bo_comb[16*i +: 16] = st_out;
    end

    ////////////////////////////////////////
    // Two-stage output pipeline
    ////////////////////////////////////////

    logic                         acc_s1;
    logic                         acc_s2;
    logic [2*PIXELS_PER_CLK-1:0]  sd_s1;
    logic [2*PIXELS_PER_CLK-1:0]  sd_s2;
    logic [16*PIXELS_PER_CLK-1:0] bo_s1;
    logic [16*PIXELS_PER_CLK-1:0] bo_s2;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_s1 <= 1'b0;
            acc_s2 <= 1'b0;
        end else begin
            acc_s1 <= accept;
            acc_s2 <= acc_s1;
        end
    end

    always_ff @(posedge clk) begin
        sd_s1 <= sd_comb;
        sd_s2 <= sd_s1;
        bo_s1 <= bo_comb;
        bo_s2 <= bo_s1;
    end

    assign sd       = acc_s2 ? sd_s2 : '0;
    assign bo_pixel = bo_s2;

    // No-stall source: data must be there whenever ready is up
    a_src_valid: assert property (
        @(posedge clk) disable iff (rst)
        region.proc_act |-> (vin_valid && bi_valid)
    );

endmodule

// ==== logic/scan_timing.sv ====
`timescale 1ns/100ps

module scan_timing import caster_pkg::*; #(
    parameter int H_FP   = 10,
    parameter int H_SYNC = 10,
    parameter int H_BP   = 120,
    parameter int H_ACT  = 400,
    parameter int V_FP   = 45,
    parameter int V_SYNC = 1,
    parameter int V_BP   = 2,
    parameter int V_ACT  = 1200
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         sys_ready,
    input  logic         vin_vsync,
    output scan_region_t region,
    output logic         frame_end
);

    // Region boundaries in counter units
    localparam logic [10:0] H_SYNC_START = 11'(H_FP);
    localparam logic [10:0] H_BP_START   = 11'(H_FP + H_SYNC);
    localparam logic [10:0] H_ACT_START  = 11'(H_FP + H_SYNC + H_BP);
    localparam logic [10:0] H_LAST       = 11'(H_FP + H_SYNC + H_BP + H_ACT - 1);
    localparam logic [10:0] V_SYNC_START = 11'(V_FP);
    localparam logic [10:0] V_BP_START   = 11'(V_FP + V_SYNC);
    localparam logic [10:0] V_ACT_START  = 11'(V_FP + V_SYNC + V_BP);
    localparam logic [10:0] V_LAST       = 11'(V_FP + V_SYNC + V_BP + V_ACT - 1);
    localparam logic [10:0] WAIT_LAST    = 11'(VS_DELAY);

    // Fetch window is the active columns moved earlier
    localparam logic [10:0] PROC_START = 11'(H_FP + H_SYNC + H_BP - PIPELINE_DELAY);
    localparam logic [10:0] PROC_END   = 11'(H_FP + H_SYNC + H_BP + H_ACT - PIPELINE_DELAY);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAITING,
        ST_RUNNING
    } scan_state_t;

    scan_state_t state;
    logic [10:0] h_cnt;
    logic [10:0] v_cnt;
    logic        h_last;
    logic        v_last;

    assign h_last = (h_cnt == H_LAST);
    assign v_last = (v_cnt == V_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    h_cnt <= '0;
                    v_cnt <= '0;
                    if (sys_ready && vin_vsync) begin
                        state <= ST_WAITING;
                    end
                end
                ST_WAITING: begin
                    // h_cnt doubles as the sync delay counter
                    if (h_cnt == WAIT_LAST) begin
                        state <= ST_RUNNING;
                        h_cnt <= '0;
                    end else begin
                        h_cnt <= h_cnt + 11'd1;
                    end
                end
                ST_RUNNING: begin
                    if (h_last) begin
                        h_cnt <= '0;
                        if (v_last) begin
                            state <= ST_IDLE;
                        end else begin
                            v_cnt <= v_cnt + 11'd1;
                        end
                    end else begin
                        h_cnt <= h_cnt + 11'd1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Region decode only while a frame runs
    always_comb begin
        region = '0;
        if (state == ST_RUNNING) begin
            region.vfp      = (v_cnt < V_SYNC_START);
            region.vsync    = (v_cnt >= V_SYNC_START) && (v_cnt < V_BP_START);
            region.vbp      = (v_cnt >= V_BP_START) && (v_cnt < V_ACT_START);
            region.vact     = (v_cnt >= V_ACT_START);
            region.hfp      = (h_cnt < H_SYNC_START);
            region.hsync    = (h_cnt >= H_SYNC_START) && (h_cnt < H_BP_START);
            region.hbp      = (h_cnt >= H_BP_START) && (h_cnt < H_ACT_START);
            region.hact     = (h_cnt >= H_ACT_START);
            region.act      = region.vact && region.hact;
            region.proc_act = region.vact && (h_cnt >= PROC_START) && (h_cnt < PROC_END);
        end
        region.waiting = (state == ST_WAITING);
    end

    assign frame_end = (state == ST_RUNNING) && h_last && v_last;

    // Frame ends on the last active pixel and hands back to idle
    a_frame_end_idle: assert property (
        @(posedge clk) disable iff (rst)
        frame_end |-> region.act ##1 (region == '0)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the caster testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --top-module caster_tb -f caster.f \
    --Mdir "$BUILD_DIR" -o caster_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/caster_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation passed"
exit 0

// ==== verif/caster_vectors.svh ====
// One fast mono decision per row, applied to a single lane
typedef struct packed {
    pixel_state_t prev_state;
    logic [3:0]   nibble;
    drive_t       exp_drive;
    pixel_state_t exp_state;
} vec_row_t;

localparam int NUM_ROWS = 16;

// Columns: previous state, input nibble, expected drive, expected state
// State word is mode[15:14] reserved[13:10] frame_cnt[9:4] prev[3:0]
localparam vec_row_t VECTORS [NUM_ROWS] = '{
    // Settled, target equals shown colour
    '{16'h4000, 4'h0, DRIVE_NONE,  16'h4000},
    '{16'h4001, 4'hF, DRIVE_NONE,  16'h4001},
    // Settled, new colour starts a full transition
    '{16'h4000, 4'h8, DRIVE_WHITE, 16'h40A1},
    '{16'h4001, 4'h7, DRIVE_BLACK, 16'h40A0},
    // Transition in progress, same target counts down
    '{16'h4051, 4'hC, DRIVE_WHITE, 16'h4041},
    '{16'h4010, 4'h3, DRIVE_BLACK, 16'h4000},
    // Reversal mid-way, 10 - count + 2
    '{16'h4031, 4'h2, DRIVE_BLACK, 16'h4090},
    '{16'h40A0, 4'h9, DRIVE_WHITE, 16'h4021},
    '{16'h4011, 4'hE, DRIVE_WHITE, 16'h4001},
    '{16'h4070, 4'hA, DRIVE_WHITE, 16'h4051},
    '{16'h40A1, 4'h8, DRIVE_WHITE, 16'h4091},
    '{16'h4020, 4'h5, DRIVE_BLACK, 16'h4010},
    // Normal LUT and reserved modes are not driven
    '{16'h0031, 4'hF, DRIVE_NONE,  16'h0000},
    '{16'h0000, 4'h8, DRIVE_NONE,  16'h0000},
    '{16'hC0A1, 4'h0, DRIVE_NONE,  16'h0000},
    '{16'hC000, 4'hF, DRIVE_NONE,  16'h0000}
};

// ==== verif/caster_tb.sv ====
`timescale 1ns/100ps

module caster_tb import caster_pkg::*; ();

    localparam int H_FP              = 2;
    localparam int H_SYNC            = 2;
    localparam int H_BP              = 4;
    localparam int H_ACT             = 4;
    localparam int V_FP              = 1;
    localparam int V_SYNC            = 1;
    localparam int V_BP              = 1;
    localparam int V_ACT             = 3;
    localparam int INIT_PHASES       = 2;
    localparam int INIT_PHASE_FRAMES = 2;

    localparam int FRAME_CYCLES = (H_FP + H_SYNC + H_BP + H_ACT) * (V_FP + V_SYNC + V_BP + V_ACT);
    localparam int ACT_CYCLES   = H_ACT * V_ACT;
    localparam int INIT_FRAMES  = INIT_PHASES * INIT_PHASE_FRAMES;
    localparam int TABLE_FRAMES = 2;
    localparam int WAIT_LIMIT   = 200;

    `include "caster_vectors.svh"

    logic        clk;
    logic        rst;
    logic        sys_ready;
    logic        vin_vsync;
    logic [15:0] vin_pixel;
    logic        vin_valid;
    logic        vin_ready;
    logic        b_trigger;
    logic [63:0] bi_pixel;
    logic        bi_valid;
    logic        bi_ready;
    logic [63:0] bo_pixel;
    logic        bo_valid;
    logic        epd_gdoe;
    logic        epd_gdclk;
    logic        epd_gdsp;
    logic        epd_sdclk;
    logic        epd_sdle;
    logic        epd_sdoe;
    logic [7:0]  epd_sd;
    logic        epd_sdce0;

    int          errors;
    int          checks;
    int          seed;
    int          frame_idx;
    int          row_idx;
    int          rdy_cnt;
    int          val_cnt;
    int          ce_cnt;
    logic        timed_out;
    logic        rdy_d1;
    logic        rdy_d2;
    logic [7:0]  exp_sd_q [$];
    logic [63:0] exp_bo_q [$];

    caster #(
        .H_FP              (H_FP),
        .H_SYNC            (H_SYNC),
        .H_BP              (H_BP),
        .H_ACT             (H_ACT),
        .V_FP              (V_FP),
        .V_SYNC            (V_SYNC),
        .V_BP              (V_BP),
        .V_ACT             (V_ACT),
        .INIT_PHASES       (INIT_PHASES),
        .INIT_PHASE_FRAMES (INIT_PHASE_FRAMES)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .sys_ready (sys_ready),
        .vin_vsync (vin_vsync),
        .vin_pixel (vin_pixel),
        .vin_valid (vin_valid),
        .vin_ready (vin_ready),
        .b_trigger (b_trigger),
        .bi_pixel  (bi_pixel),
        .bi_valid  (bi_valid),
        .bi_ready  (bi_ready),
        .bo_pixel  (bo_pixel),
        .bo_valid  (bo_valid),
        .epd_gdoe  (epd_gdoe),
        .epd_gdclk (epd_gdclk),
        .epd_gdsp  (epd_gdsp),
        .epd_sdclk (epd_sdclk),
        .epd_sdle  (epd_sdle),
        .epd_sdoe  (epd_sdoe),
        .epd_sd    (epd_sd),
        .epd_sdce0 (epd_sdce0)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////
    // Checking and run control
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    task automatic finish_run();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("Timeout after %0d cycles: %s", WAIT_LIMIT, what);
    endtask

    // Inputs change and outputs are sampled 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Even phases drive black and odd phases white with a rest in the last frame
    function automatic drive_t init_drive_for(input int f);
        drive_t drv;
        if ((f % INIT_PHASE_FRAMES) == INIT_PHASE_FRAMES - 1) begin
            drv = DRIVE_NONE;
        end else if (((f / INIT_PHASE_FRAMES) % 2) == 1) begin
            drv = DRIVE_WHITE;
        end else begin
            drv = DRIVE_BLACK;
        end
        return drv;
    endfunction

    task automatic check_reset_values();
        check_value("b_trigger", 64'(b_trigger), 64'd0);
        check_value("vin_ready", 64'(vin_ready), 64'd0);
        check_value("bi_ready", 64'(bi_ready), 64'd0);
        check_value("bo_valid", 64'(bo_valid), 64'd0);
        check_value("epd_gdoe", 64'(epd_gdoe), 64'd0);
        check_value("epd_sdoe", 64'(epd_sdoe), 64'd0);
        check_value("epd_sdle", 64'(epd_sdle), 64'd0);
        check_value("epd_gdclk", 64'(epd_gdclk), 64'd0);
        check_value("epd_sdclk", 64'(epd_sdclk), 64'd0);
        check_value("epd_gdsp", 64'(epd_gdsp), 64'd1);
        check_value("epd_sdce0", 64'(epd_sdce0), 64'd1);
        check_value("epd_sd", 64'(epd_sd), 64'd0);
    endtask

    ////////////////////////////////////////
    // Framebuffer and video source model
    ////////////////////////////////////////

    task automatic drive_word();
        vec_row_t     row;
        pixel_state_t st;
        pixel_state_t st_exp;
        drive_t       drv_exp;
        logic [3:0]   nib;
        logic [3:0]   rsv;
        logic [15:0]  vin_word;
        logic [63:0]  bi_word;
        logic [7:0]   sd_exp;
        logic [63:0]  bo_exp;
        int           lane;
        row  = VECTORS[row_idx % NUM_ROWS];
        lane = row_idx % PIXELS_PER_CLK;
        for (int l = 0; l < PIXELS_PER_CLK; l++) begin
            nib = 4'($random(seed));
            st  = pixel_state_t'(16'($random(seed)));
            if (frame_idx < INIT_FRAMES) begin
                drv_exp      = init_drive_for(frame_idx);
                st_exp       = '0;
                st_exp.mode  = MODE_FAST_MONO;
                st_exp.prev  = 4'd1;
            end else if (l == lane) begin
                rsv         = st.reserved;
                nib         = row.nibble;
                st          = row.prev_state;
                st.reserved = rsv;
                drv_exp     = row.exp_drive;
                st_exp      = row.exp_state;
                // Fast mono leaves the reserved bits alone
                if (st.mode == MODE_FAST_MONO) begin
                    st_exp.reserved = rsv;
                end
            end else begin
                // Filler lane in an unsupported mode
                st.mode = MODE_RESERVED;
                drv_exp = DRIVE_NONE;
                st_exp  = '0;
            end
            vin_word[4*l +: 4]  = nib;
            bi_word[16*l +: 16] = st;
            sd_exp[2*l +: 2]    = drv_exp;
            bo_exp[16*l +: 16]  = st_exp;
        end
        if (frame_idx >= INIT_FRAMES) begin
            row_idx++;
        end
        vin_pixel = vin_word;
        bi_pixel  = bi_word;
        vin_valid = 1'b1;
        bi_valid  = 1'b1;
        exp_sd_q.push_back(sd_exp);
        exp_bo_q.push_back(bo_exp);
    endtask

    // Check this cycle's outputs before driving its inputs
    task automatic service_cycle();
        logic [7:0]  sd_exp;
        logic [63:0] bo_exp;
        if (vin_ready === 1'b1) begin
            rdy_cnt++;
        end
        if (bo_valid === 1'b1) begin
            val_cnt++;
        end
        if (epd_sdce0 === 1'b0) begin
            ce_cnt++;
        end
        check_value("bi_ready", 64'(bi_ready), 64'(vin_ready));
        check_value("bo_valid", 64'(bo_valid), 64'(rdy_d2));
        check_value("epd_sdce0", 64'(epd_sdce0), 64'(!rdy_d2));
        if (rdy_d2 === 1'b1) begin
            if (exp_sd_q.size() == 0) begin
                errors++;
                $display("An output cycle came with no word accepted two cycles before");
            end else begin
                sd_exp = exp_sd_q.pop_front();
                bo_exp = exp_bo_q.pop_front();
                check_value("epd_sd", 64'(epd_sd), 64'(sd_exp));
                check_value("bo_pixel", bo_pixel, bo_exp);
            end
        end else begin
            check_value("epd_sd", 64'(epd_sd), 64'd0);
        end
        if (vin_ready === 1'b1) begin
            drive_word();
        end else begin
            vin_valid = 1'b0;
            bi_valid  = 1'b0;
        end
        rdy_d2 = rdy_d1;
        rdy_d1 = vin_ready;
        next_cycle();
    endtask

    task automatic run_frame();
        int err_start;
        int n;
        err_start = errors;
        n = 0;
        while (b_trigger !== 1'b1 && n < WAIT_LIMIT) begin
            service_cycle();
            n++;
        end
        if (b_trigger !== 1'b1) begin
            report_timeout("b_trigger never rose to start a frame");
            return;
        end
        n = 0;
        while (b_trigger === 1'b1 && n < WAIT_LIMIT) begin
            service_cycle();
            n++;
        end
        if (b_trigger === 1'b1) begin
            report_timeout("b_trigger never fell after the sync delay");
            return;
        end
        check_value("b_trigger cycles", 64'(n), 64'(VS_DELAY + 1));
        rdy_cnt = 0;
        val_cnt = 0;
        ce_cnt  = 0;
        repeat (FRAME_CYCLES) service_cycle();
        check_value("vin_ready cycles", 64'(rdy_cnt), 64'(ACT_CYCLES));
        check_value("bo_valid cycles", 64'(val_cnt), 64'(ACT_CYCLES));
        check_value("epd_sdce0 low cycles", 64'(ce_cnt), 64'(ACT_CYCLES));
        if (exp_sd_q.size() != 0) begin
            errors++;
            $display("Accepted words never came out by the end of frame %0d", frame_idx);
        end
        $display("Frame %0d (%s): %s, %0d errors", frame_idx,
                 (frame_idx < INIT_FRAMES) ? "init" : "table rows",
                 (errors == err_start) ? "ok" : "mismatch", errors - err_start);
        frame_idx++;
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        int err_start;
        errors    = 0;
        checks    = 0;
        seed      = 32'hc606;
        frame_idx = 0;
        row_idx   = 0;
        rdy_cnt   = 0;
        val_cnt   = 0;
        ce_cnt    = 0;
        timed_out = 1'b0;
        rdy_d1    = 1'b0;
        rdy_d2    = 1'b0;
        clk       = 1'b0;
        rst       = 1'b1;
        sys_ready = 1'b0;
        vin_vsync = 1'b0;
        vin_pixel = '0;
        vin_valid = 1'b0;
        bi_pixel  = '0;
        bi_valid  = 1'b0;

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        err_start = errors;
        for (int i = 0; i < 3; i++) begin
            check_reset_values();
            service_cycle();
        end
        $display("Reset values: %s, %0d errors",
                 (errors == err_start) ? "ok" : "mismatch", errors - err_start);

        // Vsync stays high so frames follow each other
        sys_ready = 1'b1;
        vin_vsync = 1'b1;
        for (int f = 0; f < INIT_FRAMES + TABLE_FRAMES && !timed_out; f++) begin
            run_frame();
        end
        vin_vsync = 1'b0;
        finish_run();
    end

endmodule
